/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetchCacheBench
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/benchClock.sv */
// --------------------------------------------------
// Clock and reset source for the testbench
// 40 ns period, RESET high for the first 5 edges
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module benchClock (
	output logic CLK,
	output logic RESET
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	// Released 2 ns after an edge, same as other inputs
	initial begin
		RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		RESET = 1'b0;
	end

endmodule

`default_nettype wire

/* bench/fetchCacheBench.sv */
// --------------------------------------------------
// Testbench for the fetch cache, checks are assertions
// Memory answers after 1 to 6 cycles with ~address
// Fetch addresses limited to four tags over all lines
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module fetchCacheBench;

	localparam int LINES = 1 << `INDEX_BITS;
	localparam int RANDOM_FETCHES = 200;
	localparam int DIRECTED_FETCHES = LINES + 5;
	// Worst miss is about 11 cycles, plus reset and drain
	localparam int TIMEOUT_CYCLES = 12 * (DIRECTED_FETCHES + RANDOM_FETCHES) + 5 + 20;
	localparam logic [31:0] SEED = 32'd96242;
	localparam cachePkg::addrT BASE_ADDR = 32'h0040_0000;
	localparam logic [31:0] OFFSET_MASK = (32'd1 << (`INDEX_BITS + 4)) - 32'd1;
	// Next tag, same index
	localparam logic [31:0] TAG_STEP = 32'd1 << (`INDEX_BITS + 2);

	// --------------------------------------------------
	// DUT ports
	logic CLK;
	logic RESET;
	cachePkg::addrT pc;
	logic fetchReq;
	logic ready;
	cachePkg::wordT instr;
	cachePkg::outcomeT outcome;
	logic instrValid;
	cachePkg::countT hitCount;
	cachePkg::countT missCount;
	logic memRead;
	cachePkg::addrT memAddr;
	cachePkg::wordT memData;
	logic memDone;

	// Shadow of the line array
	logic [LINES-1:0] shadowValid = '0;
	cachePkg::tagT shadowTag [LINES];

	// Expectations for the fetch in flight
	cachePkg::resultT expected;
	cachePkg::addrT expAddr;
	cachePkg::countT expHits = '0;
	cachePkg::countT expMisses = '0;
	int fetchesIssued = 0;
	int missesIssued = 0;

	// Observed tallies
	int validCount = 0;
	int memReadCount = 0;
	int sinceAccept = 0;
	int cycleCount = 0;

	logic acceptMark = 1'b0;
	logic strayReq = 1'b0;
	logic idleCheck = 1'b0;
	logic [31:0] stimState = SEED;
	logic [31:0] memState = SEED;

	benchClock clockGen (
		.CLK(CLK),
		.RESET(RESET)
	);

	// Bench signal names match the DUT ports
	fetchCache dut (.*);

	// --------------------------------------------------
	// Helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic reportValue(input string name, input logic [63:0] expValue,
		input logic [63:0] actValue);
		$display("FAILED %s: expected %0h, actual %0h", name, expValue, actValue);
		$display("Errors found");
		$fatal(1);
	endtask

	// One fetch, from the ready check to the cycle after instrValid
	task automatic runFetch(input cachePkg::addrT addr, input logic stray);
		cachePkg::indexT index;
		cachePkg::tagT tag;
		while (!ready) begin
			@(posedge CLK);
			#2;
		end
		index = addr[`INDEX_BITS+1:2];
		tag = addr[`ADDR_BITS-1:`INDEX_BITS+2];
		// Outcome from the shadow line
		if (!shadowValid[index]) begin
			expected.outcome = cachePkg::missInvalid;
		end else if (shadowTag[index] != tag) begin
			expected.outcome = cachePkg::missTag;
		end else begin
			expected.outcome = cachePkg::hit;
		end
		shadowValid[index] = 1'b1;
		shadowTag[index] = tag;
		expAddr = {addr[`ADDR_BITS-1:2], 2'b00};
		expected.data = ~expAddr;
		fetchesIssued++;
		if (expected.outcome == cachePkg::hit) begin
			expHits++;
		end else begin
			missesIssued++;
			expMisses++;
		end
		pc = addr;
		fetchReq = 1'b1;
		acceptMark = 1'b1;
		@(posedge CLK);
		#2;
		acceptMark = 1'b0;
		// Second strobe while busy, other address
		if (stray) begin
			pc = ~addr;
			strayReq = 1'b1;
			@(posedge CLK);
			#2;
			strayReq = 1'b0;
		end
		fetchReq = 1'b0;
		while (!instrValid) begin
			@(posedge CLK);
			#2;
		end
		// Keep expectations until the pulse is checked
		@(posedge CLK);
		#2;
	endtask

	// --------------------------------------------------
	// Tallies and timeout
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		sinceAccept <= acceptMark ? 0 : sinceAccept + 1;
		if (instrValid) begin
			validCount <= validCount + 1;
		end
		if (memRead) begin
			memReadCount <= memReadCount + 1;
		end
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
			$display("Errors found");
			$fatal(1);
		end
	end

	// --------------------------------------------------
	// Main memory model
	initial begin : memoryModel
		cachePkg::addrT readAddr;
		int latency;
		memDone = 1'b0;
		memData = '0;
		forever begin
			@(posedge CLK);
			#2;
			if (!RESET && memRead) begin
				readAddr = memAddr;
				memState = xorshift32(memState);
				latency = 1 + int'(memState % 32'd6);
				repeat (latency) @(posedge CLK);
				#2;
				// Data held after the pulse
				memData = ~readAddr;
				memDone = 1'b1;
				@(posedge CLK);
				#2;
				memDone = 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// Stimulus
	initial begin : stimulus
		int i;
		pc = '0;
		fetchReq = 1'b0;
		@(negedge RESET);
		@(posedge CLK);
		#2;
		idleCheck = 1'b1;
		repeat (2) @(posedge CLK);
		#2;
		idleCheck = 1'b0;
		// First touch of every line
		for (i = 0; i < LINES; i++) begin
			runFetch(BASE_ADDR + 32'(4 * i), 1'b0);
		end
		// Same word again, byte offset ignored
		runFetch(BASE_ADDR + 32'd7, 1'b1);
		// Two tags fighting over line 2
		runFetch(BASE_ADDR + 32'd8 + TAG_STEP, 1'b0);
		runFetch(BASE_ADDR + 32'd8, 1'b1);
		runFetch(BASE_ADDR + 32'd8 + TAG_STEP, 1'b0);
		runFetch(BASE_ADDR + 32'd8 + TAG_STEP, 1'b0);
		for (i = 0; i < RANDOM_FETCHES; i++) begin
			stimState = xorshift32(stimState);
			runFetch(BASE_ADDR | (stimState & OFFSET_MASK), stimState[20] & stimState[21]);
		end
		repeat (4) @(posedge CLK);
		$display("No errors");
		$finish;
	end

	// --------------------------------------------------
	// Checks
	checkIdle : assert property (@(posedge CLK)
		idleCheck |-> {ready, instrValid, memRead, hitCount, missCount} ==
			{3'b100, {(2 * `COUNT_BITS){1'b0}}})
		else reportValue("state after reset", 64'({3'b100, {(2 * `COUNT_BITS){1'b0}}}),
			64'($sampled({ready, instrValid, memRead, hitCount, missCount})));

	checkOutcome : assert property (@(posedge CLK) disable iff (RESET)
		instrValid |-> outcome == expected.outcome)
		else reportValue("outcome", 64'($sampled(expected.outcome)), 64'($sampled(outcome)));

	checkInstr : assert property (@(posedge CLK) disable iff (RESET)
		instrValid |-> instr == expected.data)
		else reportValue("instr", 64'($sampled(expected.data)), 64'($sampled(instr)));

	// Two edges from accept to result
	checkHitLatency : assert property (@(posedge CLK) disable iff (RESET)
		instrValid && expected.outcome == cachePkg::hit |-> sinceAccept == 2)
		else reportValue("hit latency", 64'd2, 64'($sampled(sinceAccept)));

	checkPulses : assert property (@(posedge CLK) disable iff (RESET)
		instrValid |-> validCount + 1 == fetchesIssued)
		else reportValue("instrValid pulses", 64'($sampled(fetchesIssued)),
			64'($sampled(validCount) + 1));

	checkCounters : assert property (@(posedge CLK) disable iff (RESET)
		instrValid |-> {hitCount, missCount} == {expHits, expMisses})
		else reportValue("hit and miss counters", 64'($sampled({expHits, expMisses})),
			64'($sampled({hitCount, missCount})));

	checkMemAddr : assert property (@(posedge CLK) disable iff (RESET)
		memRead |-> memAddr == expAddr)
		else reportValue("memAddr", 64'($sampled(expAddr)), 64'($sampled(memAddr)));

	// One read per miss, none on hits
	checkReads : assert property (@(posedge CLK) disable iff (RESET)
		memRead |-> memReadCount + 1 == missesIssued)
		else reportValue("memRead pulses", 64'($sampled(missesIssued)),
			64'($sampled(memReadCount) + 1));

	checkFillLatency : assert property (@(posedge CLK) disable iff (RESET)
		memDone |=> instrValid && instr == memData)
		else reportValue("result after memDone", 64'({1'b1, $sampled(memData)}),
			64'({$sampled(instrValid), $sampled(instr)}));

	checkStray : assert property (@(posedge CLK) disable iff (RESET)
		strayReq |-> !ready)
		else reportValue("ready under busy strobe", 64'd0, 64'($sampled(ready)));

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/cachePkg.sv
src/addrDecode.sv
src/tagStore.sv
src/missControl.sv
src/fetchResult.sv
src/fetchCache.sv
bench/benchClock.sv
bench/fetchCacheBench.sv

/* src/addrDecode.sv */
// --------------------------------------------------
// Decode stage of the fetch cache
// Request taken only when fetchReq meets ready
// Low two pc bits ignored, fetches are word aligned
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module addrDecode (
	input  logic                CLK,
	input  logic                RESET,
	input  cachePkg::addrT      pc,
	input  logic                fetchReq,
	input  logic                ready,
	output cachePkg::lookupReqT request,
	output logic                accepted
);

	cachePkg::lookupReqT pcSplit;
	logic take;

	// Split byte address into tag and index
	always_comb begin
		pcSplit.tag   = pc[`ADDR_BITS-1:`INDEX_BITS+2];
		pcSplit.index = pc[`INDEX_BITS+1:2];
	end

	// Strobes while busy are dropped
	assign take = fetchReq && ready;

	// Request register, held for the whole miss
	// so fill and memAddr see the same line
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			request  <= '0;
			accepted <= 1'b0;
		end else begin
			accepted <= take;
			if (take) begin
				request <= pcSplit;
			end
		end
	end

	// --------------------------------------------------
	// Request must not move under an access in flight
	assertRequestHeld : assert property (
		@(posedge CLK) disable iff (RESET)
		!ready |=> $stable(request)
	);

endmodule

`default_nettype wire

/* src/cachePkg.sv */
// --------------------------------------------------
// Shared types for the fetch cache
// Widths come from cache_settings.svh
// --------------------------------------------------

`default_nettype none

`include "cache_settings.svh"

package cachePkg;

	// --------------------------------------------------
	// Vector types
	typedef logic [`ADDR_BITS-1:0] addrT;
	typedef logic [31:0] wordT;
	typedef logic [`INDEX_BITS-1:0] indexT;
	// Address bits above the index, byte offset dropped
	typedef logic [`ADDR_BITS-`INDEX_BITS-3:0] tagT;
	typedef logic [`COUNT_BITS-1:0] countT;

	// --------------------------------------------------
	// Lookup outcome, same code as the old CONT output
	typedef enum logic [1:0] {
		fillDone    = 2'd0,
		hit         = 2'd1,
		missInvalid = 2'd2,
		missTag     = 2'd3
	} outcomeT;

	// Miss sequencer states
	typedef enum logic [1:0] {
		idle,
		lookup,
		waitMem
	} missStateT;

	// --------------------------------------------------
	// Bundles between stages
	typedef struct packed {
		tagT   tag;
		indexT index;
	} lookupReqT;

	typedef struct packed {
		logic valid;
		logic tagMatch;
		wordT data;
	} lookupRespT;

	typedef struct packed {
		indexT index;
		tagT   tag;
		wordT  data;
	} fillT;

	typedef struct packed {
		outcomeT outcome;
		wordT    data;
	} resultT;

endpackage

`default_nettype wire

/* src/cache_settings.svh */
// --------------------------------------------------
// Size settings for the direct-mapped fetch cache
// INDEX_BITS of 3, 4 or 5 gives 8, 16 or 32 lines
// Tag width follows as ADDR_BITS - INDEX_BITS - 2
// --------------------------------------------------

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Log2 of line count
`define INDEX_BITS 3

// Byte address width from the fetch stage
`define ADDR_BITS 32

// Hit and miss statistics counters
`define COUNT_BITS 20

`endif

/* src/fetchCache.sv */
// --------------------------------------------------
// Direct-mapped instruction fetch cache, top level
// Blocking, a fetch is honored only while ready
// Memory read answered by a one-cycle memDone
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module fetchCache (
	input  logic              CLK,
	input  logic              RESET,
	// Fetch side
	input  cachePkg::addrT    pc,
	input  logic              fetchReq,
	output logic              ready,
	output cachePkg::wordT    instr,
	output cachePkg::outcomeT outcome,
	output logic              instrValid,
	output cachePkg::countT   hitCount,
	output cachePkg::countT   missCount,
	// Main memory side
	output logic              memRead,
	output cachePkg::addrT    memAddr,
	input  cachePkg::wordT    memData,
	input  logic              memDone
);

	// --------------------------------------------------
	// Stage links
	cachePkg::lookupReqT request;
	cachePkg::lookupRespT response;
	cachePkg::fillT fill;
	cachePkg::resultT result;
	logic accepted;
	logic fillEn;
	logic done;

	addrDecode decode (
		.CLK(CLK),
		.RESET(RESET),
		.pc(pc),
		.fetchReq(fetchReq),
		.ready(ready),
		.request(request),
		.accepted(accepted)
	);

	tagStore store (
		.CLK(CLK),
		.RESET(RESET),
		.request(request),
		.fill(fill),
		.fillEn(fillEn),
		.response(response)
	);

	// Sequencer also owns ready and the memory port
	missControl control (
		.CLK(CLK),
		.RESET(RESET),
		.accepted(accepted),
		.request(request),
		.response(response),
		.memDone(memDone),
		.memData(memData),
		.memRead(memRead),
		.memAddr(memAddr),
		.fill(fill),
		.fillEn(fillEn),
		.result(result),
		.done(done),
		.ready(ready)
	);

	fetchResult resultStage (
		.CLK(CLK),
		.RESET(RESET),
		.result(result),
		.done(done),
		.instr(instr),
		.outcome(outcome),
		.instrValid(instrValid),
		.hitCount(hitCount),
		.missCount(missCount)
	);

endmodule

`default_nettype wire

/* src/fetchResult.sv */
// --------------------------------------------------
// Result stage, registers word and outcome on done
// Counters saturate at all ones instead of wrapping
// instr and outcome hold between pulses
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module fetchResult (
	input  logic               CLK,
	input  logic               RESET,
	input  cachePkg::resultT   result,
	input  logic               done,
	output cachePkg::wordT     instr,
	output cachePkg::outcomeT  outcome,
	output logic               instrValid,
	output cachePkg::countT    hitCount,
	output cachePkg::countT    missCount
);

	localparam cachePkg::countT COUNT_MAX = '1;

	logic isHit;
	logic isMiss;

	assign isHit = result.outcome == cachePkg::hit;
	// fillDone never reaches here, both miss kinds count
	assign isMiss = (result.outcome == cachePkg::missInvalid) ||
		(result.outcome == cachePkg::missTag);

	// --------------------------------------------------
	// Control and statistics
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instrValid <= 1'b0;
			outcome    <= cachePkg::fillDone;
			hitCount   <= '0;
			missCount  <= '0;
		end else begin
			instrValid <= done;
			if (done) begin
				outcome <= result.outcome;
				if (isHit && hitCount != COUNT_MAX) begin
					hitCount <= hitCount + 1'b1;
				end
				if (isMiss && missCount != COUNT_MAX) begin
					missCount <= missCount + 1'b1;
				end
			end
		end
	end

	// Word payload
	always_ff @(posedge CLK) begin
		if (done) begin
			instr <= result.data;
		end
	end

endmodule

`default_nettype wire

/* src/missControl.sv */
// --------------------------------------------------
// Miss sequencer, one access in flight at a time
// Memory latency must be at least one cycle
// memAddr held from the lookup cycle until the fill
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module missControl (
	input  logic                 CLK,
	input  logic                 RESET,
	input  logic                 accepted,
	input  cachePkg::lookupReqT  request,
	input  cachePkg::lookupRespT response,
	input  logic                 memDone,
	input  cachePkg::wordT       memData,
	output logic                 memRead,
	output cachePkg::addrT       memAddr,
	output cachePkg::fillT       fill,
	output logic                 fillEn,
	output cachePkg::resultT     result,
	output logic                 done,
	output logic                 ready
);

	cachePkg::missStateT state;
	cachePkg::missStateT nextState;
	cachePkg::outcomeT missKind;
	logic hitNow;

	assign hitNow = response.valid && response.tagMatch;

	// --------------------------------------------------
	// State and miss kind registers
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state    <= cachePkg::idle;
			missKind <= cachePkg::missInvalid;
		end else begin
			state <= nextState;
			// Kind of miss kept for the final outcome
			if (state == cachePkg::lookup && !hitNow) begin
				missKind <= response.valid ? cachePkg::missTag : cachePkg::missInvalid;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			cachePkg::idle:    if (accepted) nextState = cachePkg::lookup;
			cachePkg::lookup:  nextState = hitNow ? cachePkg::idle : cachePkg::waitMem;
			cachePkg::waitMem: if (memDone) nextState = cachePkg::idle;
			default:           nextState = cachePkg::idle;
		endcase
	end

	// --------------------------------------------------
	// Outputs
	// Busy also in the cycle the decode register loads
	assign ready = (state == cachePkg::idle) && !accepted;

	// Miss decided in lookup, read issued the same cycle
	assign memRead = (state == cachePkg::lookup) && !hitNow;
	assign memAddr = {request.tag, request.index, 2'b00};

	assign fillEn = (state == cachePkg::waitMem) && memDone;
	assign fill = '{index: request.index, tag: request.tag, data: memData};

	assign done = ((state == cachePkg::lookup) && hitNow) || fillEn;

	always_comb begin
		if (state == cachePkg::lookup) begin
			result = '{outcome: cachePkg::hit, data: response.data};
		end else begin
			result = '{outcome: missKind, data: memData};
		end
	end

	// --------------------------------------------------
	assertDoneInWait : assert property (
		@(posedge CLK) disable iff (RESET)
		memDone |-> state == cachePkg::waitMem
	);

	assertReadPulse : assert property (
		@(posedge CLK) disable iff (RESET)
		memRead |=> !memRead
	);

endmodule

`default_nettype wire

/* src/tagStore.sv */
// --------------------------------------------------
// Line array, one 32-bit word per line
// Only valid bits are reset, tags and data are not
// Lookup is combinational from the registered request
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module tagStore (
	input  logic                 CLK,
	input  logic                 RESET,
	input  cachePkg::lookupReqT  request,
	input  cachePkg::fillT       fill,
	input  logic                 fillEn,
	output cachePkg::lookupRespT response
);

	localparam int LINES = 1 << `INDEX_BITS;

	// --------------------------------------------------
	// Storage
	logic [LINES-1:0] validBits;
	cachePkg::tagT tagArray [LINES];
	cachePkg::wordT dataArray [LINES];

	logic lineValid;

	// Valid bits, all lines invalid out of reset
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			validBits <= '0;
		end else if (fillEn) begin
			validBits[fill.index] <= 1'b1;
		end
	end

	// Tag and data written together on fill
	always_ff @(posedge CLK) begin
		if (fillEn) begin
			tagArray[fill.index]  <= fill.tag;
			dataArray[fill.index] <= fill.data;
		end
	end

	// --------------------------------------------------
	// Lookup of the addressed line
	assign lineValid = validBits[request.index];

	always_comb begin
		response.valid = lineValid;
		// Match masked by valid, stale tags never count
		response.tagMatch = lineValid && (tagArray[request.index] == request.tag);
		response.data = dataArray[request.index];
	end

	// --------------------------------------------------
	// Freshly filled line hits on the held request
	assertFillHits : assert property (
		@(posedge CLK) disable iff (RESET)
		fillEn |=> response.valid && response.tagMatch
	);

endmodule

`default_nettype wire
